// ==== src/chip8_isa_pkg.sv ====
`default_nettype none

package chip8_isa_pkg;

   localparam int ADDR_W = 12;
   localparam int BYTE_W = 8;
   localparam int NIB_W  = 4;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [BYTE_W-1:0] byte_t;
   typedef logic [NIB_W-1:0]  reg_idx_t;
   typedef logic [NIB_W-1:0]  nib_t;

   localparam addr_t    PROG_START  = 12'h200;
   localparam int       MEM_BYTES   = 1 << ADDR_W;
   localparam int       NUM_REGS    = 16;
   localparam reg_idx_t FLAG_REG    = 4'hF;   // VF
   localparam int       STACK_DEPTH = 16;

   // Fx second byte
   localparam byte_t MISC_ADD_I = 8'h1E;
   localparam byte_t MISC_STORE = 8'h55;
   localparam byte_t MISC_LOAD  = 8'h65;
   localparam byte_t RET_BYTE   = 8'hEE;   // 00EE

   typedef enum logic [3:0] {
      op_sys      = 4'h0,
      op_jp       = 4'h1,
      op_call     = 4'h2,
      op_se_byte  = 4'h3,
      op_sne_byte = 4'h4,
      op_se_reg   = 4'h5,
      op_ld_byte  = 4'h6,
      op_add_byte = 4'h7,
      op_alu      = 4'h8,
      op_sne_reg  = 4'h9,
      op_ld_i     = 4'hA,
      op_jp_v0    = 4'hB,
      op_rnd      = 4'hC,
      op_drw      = 4'hD,
      op_skp      = 4'hE,
      op_misc     = 4'hF
   } opcode_e;

   typedef enum logic [3:0] {
      alu_ld   = 4'h0,
      alu_or   = 4'h1,
      alu_and  = 4'h2,
      alu_xor  = 4'h3,
      alu_add  = 4'h4,
      alu_sub  = 4'h5,
      alu_shr  = 4'h6,
      alu_subn = 4'h7,
      alu_shl  = 4'hE
   } alu_fn_e;

   // one instruction word, hi byte first
   typedef struct packed {
      opcode_e  op;
      reg_idx_t x;
      reg_idx_t y;
      nib_t     n;
   } instr_t;

endpackage

`default_nettype wire

// ==== src/chip8_core_pkg.sv ====
`default_nettype none

package chip8_core_pkg;

   localparam int SP_W = $clog2(chip8_isa_pkg::STACK_DEPTH);

   typedef logic [SP_W-1:0] sp_t;

   // Fx65 counts to x+1, one past the last register
   typedef logic [4:0] xfer_cnt_t;

   typedef enum logic [2:0] {
      st_idle,
      st_rd_hi,
      st_rd_lo,
      st_exec,
      st_alu_flag,
      st_xfer_rd,
      st_xfer_wr
   } seq_state_e;

   typedef struct packed {
      logic                    en;
      chip8_isa_pkg::reg_idx_t idx;
      chip8_isa_pkg::byte_t    data;
   } reg_wr_t;

   typedef struct packed {
      logic                 en;
      chip8_isa_pkg::addr_t addr;
      chip8_isa_pkg::byte_t data;
   } mem_wr_t;

endpackage

`default_nettype wire

// ==== src/program_mem.sv ====
`default_nettype none

module program_mem (
   input  wire                            clk,
   input  wire  chip8_core_pkg::mem_wr_t  wr_i,
   input  wire  chip8_isa_pkg::addr_t     raddr_i,
   output chip8_isa_pkg::byte_t           q_o
);

   chip8_isa_pkg::byte_t ram [chip8_isa_pkg::MEM_BYTES];

   always_ff @(posedge clk)
   begin
      if (wr_i.en)
         ram[wr_i.addr] <= wr_i.data;
      q_o <= ram[raddr_i];   // old data on a same-address write
   end

endmodule

`default_nettype wire

// ==== src/v_reg_file.sv ====
`default_nettype none

module v_reg_file (
   input  wire                            clk,
   input  wire                            rst_n_i,
   input  wire  chip8_core_pkg::reg_wr_t  wr_i,
   input  wire  chip8_isa_pkg::reg_idx_t  rd_x_i,
   input  wire  chip8_isa_pkg::reg_idx_t  rd_y_i,
   output chip8_isa_pkg::byte_t           vx_o,
   output chip8_isa_pkg::byte_t           vy_o
);

   chip8_isa_pkg::byte_t v_q [chip8_isa_pkg::NUM_REGS];

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         for (int i = 0; i < chip8_isa_pkg::NUM_REGS; i++)
            v_q[i] <= '0;
      end
      else if (wr_i.en)
         v_q[wr_i.idx] <= wr_i.data;
   end

   assign vx_o = v_q[rd_x_i];
   assign vy_o = v_q[rd_y_i];

endmodule

`default_nettype wire

// ==== src/alu_8xy.sv ====
`default_nettype none

module alu_8xy (
   input  wire  chip8_isa_pkg::alu_fn_e  fn_i,
   input  wire  chip8_isa_pkg::byte_t    vx_i,
   input  wire  chip8_isa_pkg::byte_t    vy_i,
   output chip8_isa_pkg::byte_t          res_o,
   output logic                          flag_o
);

   always_comb
   begin
      res_o  = vx_i;
      flag_o = 1'b0;
      case (fn_i)
         chip8_isa_pkg::alu_ld:
            res_o = vy_i;
         chip8_isa_pkg::alu_or:
            res_o = vx_i | vy_i;
         chip8_isa_pkg::alu_and:
            res_o = vx_i & vy_i;
         chip8_isa_pkg::alu_xor:
            res_o = vx_i ^ vy_i;
         chip8_isa_pkg::alu_add:
            {flag_o, res_o} = vx_i + vy_i;   // carry out
         chip8_isa_pkg::alu_sub:
         begin
            res_o  = vx_i - vy_i;
            flag_o = (vx_i >= vy_i);   // no borrow
         end
         chip8_isa_pkg::alu_shr:
         begin
            res_o  = vx_i >> 1;
            flag_o = vx_i[0];
         end
         chip8_isa_pkg::alu_subn:
         begin
            res_o  = vy_i - vx_i;
            flag_o = (vy_i >= vx_i);
         end
         chip8_isa_pkg::alu_shl:
         begin
            res_o  = vx_i << 1;
            flag_o = vx_i[7];
         end
         default:
            res_o = vx_i;   // undefined fn, not written back
      endcase
   end

endmodule

`default_nettype wire

// ==== src/call_stack.sv ====
`default_nettype none

module call_stack (
   input  wire                         clk,
   input  wire                         rst_n_i,
   input  wire                         push_i,
   input  wire                         pop_i,
   input  wire  chip8_isa_pkg::addr_t  push_addr_i,
   output chip8_isa_pkg::addr_t        top_o
);

   chip8_isa_pkg::addr_t stk [chip8_isa_pkg::STACK_DEPTH];
   chip8_core_pkg::sp_t  sp_q;   // next free slot

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         sp_q <= '0;
      else if (push_i)
         sp_q <= sp_q + 1'b1;
      else if (pop_i)
         sp_q <= sp_q - 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (push_i)
         stk[sp_q] <= push_addr_i;
   end

   assign top_o = stk[chip8_core_pkg::sp_t'(sp_q - 1'b1)];

   a_push_pop_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(push_i && pop_i));

endmodule

`default_nettype wire

// ==== src/instr_sequencer.sv ====
`default_nettype none

module instr_sequencer (
   input  wire                            clk,
   input  wire                            rst_n_i,
   input  wire                            run_i,
   input  wire  chip8_isa_pkg::byte_t     mem_q_i,
   input  wire  chip8_isa_pkg::byte_t     vx_i,
   input  wire  chip8_isa_pkg::byte_t     vy_i,
   input  wire  chip8_isa_pkg::byte_t     alu_res_i,
   input  wire                            alu_flag_i,
   input  wire  chip8_isa_pkg::addr_t     stack_top_i,
   output chip8_isa_pkg::addr_t           mem_raddr_o,
   output chip8_core_pkg::mem_wr_t        mem_wr_o,
   output chip8_core_pkg::reg_wr_t        reg_wr_o,
   output chip8_isa_pkg::reg_idx_t        rd_x_o,
   output chip8_isa_pkg::reg_idx_t        rd_y_o,
   output chip8_isa_pkg::alu_fn_e         alu_fn_o,
   output logic                           push_o,
   output logic                           pop_o,
   output chip8_isa_pkg::addr_t           push_addr_o,
   output logic                           retire_o,
   output chip8_isa_pkg::addr_t           retire_pc_o
);

   chip8_core_pkg::seq_state_e  st_q;
   chip8_core_pkg::seq_state_e  st_d;
   chip8_isa_pkg::addr_t        pc_q;
   chip8_isa_pkg::addr_t        pc_nxt;
   chip8_isa_pkg::addr_t        i_q;
   chip8_isa_pkg::addr_t        xfer_addr;
   chip8_isa_pkg::instr_t       ir_q;
   chip8_isa_pkg::instr_t       cur;
   chip8_isa_pkg::byte_t        kk;
   chip8_isa_pkg::addr_t        nnn;
   chip8_core_pkg::xfer_cnt_t   cnt_q;
   logic [chip8_core_pkg::SP_W:0] stk_lvl;   // entries in use
   logic                        flag_q;
   logic                        done;
   logic                        in_exec;
   logic                        is_ret;
   logic                        is_store;
   logic                        is_load;
   logic                        alu_wr;
   logic                        alu_two;

   // low byte comes straight off the memory in exec
   assign in_exec = (st_q == chip8_core_pkg::st_exec);
   assign cur     = in_exec ? {ir_q[15:8], mem_q_i} : ir_q;
   assign kk      = {cur.y, cur.n};
   assign nnn     = {cur.x, cur.y, cur.n};

   assign is_ret   = (cur.op == chip8_isa_pkg::op_sys) && (kk == chip8_isa_pkg::RET_BYTE);
   assign is_store = (cur.op == chip8_isa_pkg::op_misc) && (kk == chip8_isa_pkg::MISC_STORE);
   assign is_load  = (cur.op == chip8_isa_pkg::op_misc) && (kk == chip8_isa_pkg::MISC_LOAD);

   assign alu_fn_o  = chip8_isa_pkg::alu_fn_e'(cur.n);
   assign xfer_addr = i_q + chip8_isa_pkg::addr_t'(cnt_q);

   always_comb
   begin
      alu_wr  = 1'b1;
      alu_two = 1'b0;
      case (alu_fn_o)
         chip8_isa_pkg::alu_ld, chip8_isa_pkg::alu_or,
         chip8_isa_pkg::alu_and, chip8_isa_pkg::alu_xor:
            alu_two = 1'b0;
         chip8_isa_pkg::alu_add, chip8_isa_pkg::alu_sub, chip8_isa_pkg::alu_shr,
         chip8_isa_pkg::alu_subn, chip8_isa_pkg::alu_shl:
            alu_two = 1'b1;   // VF follows next cycle
         default:
            alu_wr = 1'b0;
      endcase
   end

   always_comb
   begin
      rd_x_o = cur.x;
      if (st_q == chip8_core_pkg::st_xfer_wr)
         rd_x_o = chip8_isa_pkg::reg_idx_t'(cnt_q);
      else if (cur.op == chip8_isa_pkg::op_jp_v0)
         rd_x_o = '0;   // V0 offset
   end

   assign rd_y_o = cur.y;

   always_comb
   begin
      st_d = st_q;
      done = 1'b0;
      case (st_q)
         chip8_core_pkg::st_idle:
            if (run_i)
               st_d = chip8_core_pkg::st_rd_hi;
         chip8_core_pkg::st_rd_hi:
            st_d = chip8_core_pkg::st_rd_lo;
         chip8_core_pkg::st_rd_lo:
            st_d = chip8_core_pkg::st_exec;
         chip8_core_pkg::st_exec:
            if (cur.op == chip8_isa_pkg::op_alu && alu_two)
               st_d = chip8_core_pkg::st_alu_flag;
            else if (is_store)
               st_d = chip8_core_pkg::st_xfer_wr;
            else if (is_load)
               st_d = chip8_core_pkg::st_xfer_rd;
            else
               done = 1'b1;
         chip8_core_pkg::st_alu_flag:
            done = 1'b1;
         chip8_core_pkg::st_xfer_wr:
            done = (chip8_isa_pkg::reg_idx_t'(cnt_q) == cur.x);
         chip8_core_pkg::st_xfer_rd:
            done = (cnt_q == chip8_core_pkg::xfer_cnt_t'(cur.x) + 1'b1);   // last write
         default:
            st_d = chip8_core_pkg::st_idle;
      endcase
      if (done)
         st_d = chip8_core_pkg::st_idle;
   end

   always_comb
   begin
      pc_nxt = pc_q + 12'd2;
      if (in_exec)
      begin
         case (cur.op)
            chip8_isa_pkg::op_sys:
               if (is_ret)
                  pc_nxt = stack_top_i;
            chip8_isa_pkg::op_jp, chip8_isa_pkg::op_call:
               pc_nxt = nnn;
            chip8_isa_pkg::op_se_byte:
               if (vx_i == kk)
                  pc_nxt = pc_q + 12'd4;
            chip8_isa_pkg::op_sne_byte:
               if (vx_i != kk)
                  pc_nxt = pc_q + 12'd4;
            chip8_isa_pkg::op_se_reg:
               if (vx_i == vy_i)
                  pc_nxt = pc_q + 12'd4;
            chip8_isa_pkg::op_sne_reg:
               if (vx_i != vy_i)
                  pc_nxt = pc_q + 12'd4;
            chip8_isa_pkg::op_jp_v0:
               pc_nxt = nnn + chip8_isa_pkg::addr_t'(vx_i);   // wraps at 12 bits
            default:
               pc_nxt = pc_q + 12'd2;
         endcase
      end
   end

   always_comb
   begin
      case (st_q)
         chip8_core_pkg::st_rd_lo:   mem_raddr_o = pc_q + 12'd1;
         chip8_core_pkg::st_xfer_rd: mem_raddr_o = xfer_addr;
         default:                    mem_raddr_o = pc_q;
      endcase
   end

   assign mem_wr_o = '{en: (st_q == chip8_core_pkg::st_xfer_wr), addr: xfer_addr, data: vx_i};

   always_comb
   begin
      reg_wr_o = '0;
      case (st_q)
         chip8_core_pkg::st_exec:
            case (cur.op)
               chip8_isa_pkg::op_ld_byte:
                  reg_wr_o = '{en: 1'b1, idx: cur.x, data: kk};
               chip8_isa_pkg::op_add_byte:
                  reg_wr_o = '{en: 1'b1, idx: cur.x, data: vx_i + kk};   // no carry
               chip8_isa_pkg::op_alu:
                  reg_wr_o = '{en: alu_wr, idx: cur.x, data: alu_res_i};
               default:
                  reg_wr_o = '0;
            endcase
         chip8_core_pkg::st_alu_flag:
            reg_wr_o = '{en: 1'b1, idx: chip8_isa_pkg::FLAG_REG,
                         data: chip8_isa_pkg::byte_t'(flag_q)};
         chip8_core_pkg::st_xfer_rd:
            // data for register cnt-1 arrives now
            if (cnt_q != '0)
               reg_wr_o = '{en: 1'b1, idx: chip8_isa_pkg::reg_idx_t'(cnt_q - 1'b1),
                            data: mem_q_i};
         default:
            reg_wr_o = '0;
      endcase
   end

   assign push_o      = in_exec && (cur.op == chip8_isa_pkg::op_call);
   assign pop_o       = in_exec && is_ret;
   assign push_addr_o = pc_q + 12'd2;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         st_q     <= chip8_core_pkg::st_idle;
         pc_q     <= chip8_isa_pkg::PROG_START;
         i_q      <= '0;
         cnt_q    <= '0;
         stk_lvl  <= '0;
         retire_o <= 1'b0;
      end
      else
      begin
         st_q     <= st_d;
         retire_o <= done;
         if (done)
            pc_q <= pc_nxt;
         if (in_exec)
            cnt_q <= '0;
         else if (st_q == chip8_core_pkg::st_xfer_wr || st_q == chip8_core_pkg::st_xfer_rd)
            cnt_q <= cnt_q + 1'b1;
         if (in_exec && cur.op == chip8_isa_pkg::op_ld_i)
            i_q <= nnn;
         else if (in_exec && cur.op == chip8_isa_pkg::op_misc
                  && kk == chip8_isa_pkg::MISC_ADD_I)
            i_q <= i_q + chip8_isa_pkg::addr_t'(vx_i);   // VF untouched
         if (push_o)
            stk_lvl <= stk_lvl + 1'b1;
         else if (pop_o)
            stk_lvl <= stk_lvl - 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (st_q == chip8_core_pkg::st_rd_lo)
         ir_q[15:8] <= mem_q_i;
      if (in_exec)
      begin
         ir_q   <= cur;
         flag_q <= alu_flag_i;   // ALU inputs change once Vx is written
      end
      if (done)
         retire_pc_o <= pc_q;
   end

   a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n_i)
      pop_o |-> stk_lvl != '0);

   a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n_i)
      push_o |-> stk_lvl < chip8_isa_pkg::STACK_DEPTH);

   // a write while stopped would be dropped by the top mux
   a_no_wr_stopped: assert property (@(posedge clk) disable iff (!rst_n_i)
      mem_wr_o.en |-> run_i);

endmodule

`default_nettype wire

// ==== src/chip8_top.sv ====
`default_nettype none

module chip8_top (
   input  wire                            clk,
   input  wire                            rst_n_i,
   input  wire                            run_i,
   input  wire                            load_we_i,
   input  wire  chip8_isa_pkg::addr_t     load_addr_i,
   input  wire  chip8_isa_pkg::byte_t     load_data_i,
   output chip8_core_pkg::reg_wr_t        vwr_o,
   output logic                           retire_o,
   output chip8_isa_pkg::addr_t           retire_pc_o
);

   wire chip8_isa_pkg::addr_t     mem_raddr;
   wire chip8_isa_pkg::byte_t     mem_q;
   wire chip8_isa_pkg::byte_t     vx;
   wire chip8_isa_pkg::byte_t     vy;
   wire chip8_isa_pkg::byte_t     alu_res;
   wire                           alu_flag;
   wire chip8_isa_pkg::alu_fn_e   alu_fn;
   wire chip8_isa_pkg::reg_idx_t  rd_x;
   wire chip8_isa_pkg::reg_idx_t  rd_y;
   wire chip8_isa_pkg::addr_t     stack_top;
   wire chip8_isa_pkg::addr_t     push_addr;
   wire                           push;
   wire                           pop;
   wire chip8_core_pkg::reg_wr_t  reg_wr;
   wire chip8_core_pkg::mem_wr_t  seq_mem_wr;
   wire chip8_core_pkg::mem_wr_t  load_wr;
   wire chip8_core_pkg::mem_wr_t  mem_wr;

   assign load_wr = '{en: load_we_i, addr: load_addr_i, data: load_data_i};
   assign mem_wr  = run_i ? seq_mem_wr : load_wr;   // loader owns memory while stopped
   assign vwr_o   = reg_wr;

   instr_sequencer u_seq (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .run_i       (run_i),
      .mem_q_i     (mem_q),
      .vx_i        (vx),
      .vy_i        (vy),
      .alu_res_i   (alu_res),
      .alu_flag_i  (alu_flag),
      .stack_top_i (stack_top),
      .mem_raddr_o (mem_raddr),
      .mem_wr_o    (seq_mem_wr),
      .reg_wr_o    (reg_wr),
      .rd_x_o      (rd_x),
      .rd_y_o      (rd_y),
      .alu_fn_o    (alu_fn),
      .push_o      (push),
      .pop_o       (pop),
      .push_addr_o (push_addr),
      .retire_o    (retire_o),
      .retire_pc_o (retire_pc_o)
   );

   call_stack u_stack (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .push_i      (push),
      .pop_i       (pop),
      .push_addr_i (push_addr),
      .top_o       (stack_top)
   );

   v_reg_file u_vregs (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .wr_i    (reg_wr),
      .rd_x_i  (rd_x),
      .rd_y_i  (rd_y),
      .vx_o    (vx),
      .vy_o    (vy)
   );

   alu_8xy u_alu (
      .fn_i   (alu_fn),
      .vx_i   (vx),
      .vy_i   (vy),
      .res_o  (alu_res),
      .flag_o (alu_flag)
   );

   program_mem u_mem (
      .clk     (clk),
      .wr_i    (mem_wr),
      .raddr_i (mem_raddr),
      .q_o     (mem_q)
   );

endmodule

`default_nettype wire

// ==== sim/chip8_checker.sv ====
`default_nettype none

module chip8_checker (
   input  wire                            clk,
   input  wire                            rst_n_i,
   input  wire                            run_i,
   input  wire                            load_we_i,
   input  wire  chip8_isa_pkg::addr_t     load_addr_i,
   input  wire  chip8_isa_pkg::byte_t     load_data_i,
   input  wire  chip8_core_pkg::reg_wr_t  vwr_i,
   input  wire                            retire_i,
   input  wire  chip8_isa_pkg::addr_t     retire_pc_i,
   output logic                           done_o,
   output logic                           next_store_o,
   output int                             err_cnt_o,
   output int                             retire_cnt_o
);

   localparam int STOP_SLACK = 24;   // longer than any instruction

   chip8_isa_pkg::byte_t  mem [4096];
   chip8_isa_pkg::byte_t  v [16];
   chip8_isa_pkg::addr_t  stk [16];
   chip8_isa_pkg::addr_t  pc;
   chip8_isa_pkg::addr_t  i_reg;
   chip8_isa_pkg::addr_t  cur_pc;
   logic [11:0]           exp_q [$];   // {idx, data}
   logic [11:0]           got;
   logic                  have_cur;
   int                    sp;
   int                    low_cycles;

   initial
   begin
      err_cnt_o    = 0;
      retire_cnt_o = 0;
   end

   task automatic expect_write(input logic [3:0] idx, input chip8_isa_pkg::byte_t data);
      begin
         exp_q.push_back({idx, data});
         v[idx] = data;
      end
   endtask

   // one instruction at the ISA level
   task automatic exec_next();
      logic [15:0]          w;
      logic [3:0]           op;
      logic [3:0]           x;
      logic [3:0]           y;
      logic [3:0]           n;
      logic [8:0]           sum;
      chip8_isa_pkg::byte_t kk;
      chip8_isa_pkg::byte_t vx;
      chip8_isa_pkg::byte_t vy;
      chip8_isa_pkg::byte_t res;
      chip8_isa_pkg::addr_t nnn;
      logic                 flag;
      int                   j;
      begin
         w      = {mem[pc], mem[pc + 12'd1]};
         cur_pc = pc;
         op     = w[15:12];
         x      = w[11:8];
         y      = w[7:4];
         n      = w[3:0];
         kk     = w[7:0];
         nnn    = w[11:0];
         vx     = v[x];
         vy     = v[y];
         pc     = cur_pc + 12'd2;
         next_store_o = (op == 4'hF) && (kk == 8'h55);   // Fx55 about to run
         case (op)
            4'h0:
               if (kk == 8'hEE)
               begin
                  sp = sp - 1;
                  pc = stk[sp];
               end
            4'h1:
            begin
               pc = nnn;
               if (nnn == cur_pc)
                  done_o = 1'b1;   // self-jump ends the program
            end
            4'h2:
            begin
               stk[sp] = cur_pc + 12'd2;
               sp      = sp + 1;
               pc      = nnn;
            end
            4'h3:
               if (vx == kk)
                  pc = cur_pc + 12'd4;
            4'h4:
               if (vx != kk)
                  pc = cur_pc + 12'd4;
            4'h5:
               if (vx == vy)
                  pc = cur_pc + 12'd4;
            4'h9:
               if (vx != vy)
                  pc = cur_pc + 12'd4;
            4'h6: expect_write(x, kk);
            4'h7: expect_write(x, vx + kk);
            4'h8:
               case (n)
                  4'h0: expect_write(x, vy);
                  4'h1: expect_write(x, vx | vy);
                  4'h2: expect_write(x, vx & vy);
                  4'h3: expect_write(x, vx ^ vy);
                  4'h4, 4'h5, 4'h6, 4'h7, 4'hE:
                  begin
                     sum = {1'b0, vx} + {1'b0, vy};
                     case (n)
                        4'h4:
                        begin
                           res  = sum[7:0];
                           flag = sum[8];
                        end
                        4'h5:
                        begin
                           res  = vx - vy;
                           flag = (vx >= vy);
                        end
                        4'h6:
                        begin
                           res  = vx >> 1;
                           flag = vx[0];
                        end
                        4'h7:
                        begin
                           res  = vy - vx;
                           flag = (vy >= vx);
                        end
                        default:
                        begin
                           res  = vx << 1;
                           flag = vx[7];
                        end
                     endcase
                     expect_write(x, res);
                     expect_write(4'hF, {7'd0, flag});   // flag after result
                  end
                  default: ;   // undefined fn writes nothing
               endcase
            4'hA: i_reg = nnn;
            4'hB: pc = nnn + {4'h0, v[0]};
            4'hF:
               case (kk)
                  8'h1E: i_reg = i_reg + {4'h0, vx};
                  8'h55:
                     for (j = 0; j <= x; j++)
                        mem[chip8_isa_pkg::addr_t'(i_reg + j)] = v[j];
                  8'h65:
                     for (j = 0; j <= x; j++)
                        expect_write(4'(j), mem[chip8_isa_pkg::addr_t'(i_reg + j)]);
                  default: ;
               endcase
            default: ;   // dropped opcodes retire silently
         endcase
      end
   endtask

   always @(negedge clk)
   begin
      if (!rst_n_i)
      begin
         for (int r = 0; r < 16; r++)
            v[r] = '0;
         pc           = 12'h200;
         i_reg        = '0;
         cur_pc       = 12'h200;
         sp           = 0;
         have_cur     = 1'b0;
         done_o       = 1'b0;
         next_store_o = 1'b0;
         low_cycles   = 0;
         exp_q.delete();
      end
      else
      begin
         if (load_we_i && !run_i)
            mem[load_addr_i] = load_data_i;
         if (run_i)
            low_cycles = 0;
         else
            low_cycles++;
         if (run_i && !have_cur)
         begin
            exec_next();
            have_cur = 1'b1;
         end
         if (vwr_i.en)
         begin
            if (exp_q.size() == 0)
            begin
               $display("** Error at %0t: unexpected write V%0h=%02h", $time,
                        vwr_i.idx, vwr_i.data);
               err_cnt_o++;
            end
            else
            begin
               got = exp_q.pop_front();
               if (got != {vwr_i.idx, vwr_i.data})
               begin
                  $display("** Error at %0t: write V%0h=%02h, expected V%0h=%02h", $time,
                           vwr_i.idx, vwr_i.data, got[11:8], got[7:0]);
                  err_cnt_o++;
               end
            end
         end
         if (retire_i)
         begin
            retire_cnt_o++;
            if (low_cycles > STOP_SLACK)
            begin
               $display("an instruction retired at %0t although run was low for %0d cycles",
                        $time, low_cycles);
               err_cnt_o++;
            end
            if (retire_pc_i != cur_pc)
            begin
               $display("** Error at %0t: retire pc %03h, expected %03h", $time,
                        retire_pc_i, cur_pc);
               err_cnt_o++;
            end
            if (exp_q.size() != 0)
            begin
               $display("** Error at %0t: %0d register writes missing at retire of %03h",
                        $time, exp_q.size(), cur_pc);
               err_cnt_o++;
               exp_q.delete();
            end
            if (have_cur)
               exec_next();
         end
      end
   end

endmodule

`default_nettype wire

// ==== sim/tb_chip8.sv ====
`default_nettype none

module tb_chip8;

   localparam int NUM_PROGS = 20;
   localparam int N_UNITS   = 16;
   localparam int LIMIT     = NUM_PROGS * 64 * 20;

   logic                     clk = 1'b0;
   logic                     rst_n_i;
   logic                     run_i;
   logic                     load_we_i;
   chip8_isa_pkg::addr_t     load_addr_i;
   chip8_isa_pkg::byte_t     load_data_i;
   chip8_core_pkg::reg_wr_t  vwr;
   logic                     retire;
   chip8_isa_pkg::addr_t     retire_pc;
   logic                     prog_done;
   logic                     store_next;
   int                       err_cnt;
   int                       retire_cnt;
   int                       cycles = 0;
   chip8_isa_pkg::addr_t     unit_at [N_UNITS + 1];   // last entry is the self-jump
   logic [15:0]              words [$];

   always #2 clk = ~clk;

   chip8_top u_dut (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .run_i       (run_i),
      .load_we_i   (load_we_i),
      .load_addr_i (load_addr_i),
      .load_data_i (load_data_i),
      .vwr_o       (vwr),
      .retire_o    (retire),
      .retire_pc_o (retire_pc)
   );

   chip8_checker u_chk (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .run_i        (run_i),
      .load_we_i    (load_we_i),
      .load_addr_i  (load_addr_i),
      .load_data_i  (load_data_i),
      .vwr_i        (vwr),
      .retire_i     (retire),
      .retire_pc_i  (retire_pc),
      .done_o       (prog_done),
      .next_store_o (store_next),
      .err_cnt_o    (err_cnt),
      .retire_cnt_o (retire_cnt)
   );

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles >= LIMIT)
      begin
         $display("timeout: run did not finish within %0d cycles", LIMIT);
         $display("errors: %0d, retired instructions: %0d", err_cnt, retire_cnt);
         $display("=== FAIL ===");
         $finish;
      end
   end

   function automatic int unit_len(input int ty);
      case (ty)
         1, 3:    return 2;
         4, 5:    return 3;
         default: return 1;
      endcase
   endfunction

   function automatic logic [15:0] rand_simple();
      logic [3:0] x;
      logic [3:0] y;
      logic [3:0] n;
      logic [7:0] kk;
      begin
         x  = 4'($urandom);
         y  = 4'($urandom);
         kk = 8'($urandom);
         n  = 4'($urandom % 10);
         if (n == 4'd9)
            n = 4'hE;   // 8 stays as an undefined fn
         case ($urandom % 8)
            0, 7:       return {4'h6, x, kk};
            1:          return {4'h7, x, kk};
            2, 3, 4, 5: return {4'h8, x, y, n};
            default:
               case ($urandom % 6)
                  0:       return 16'h00E0;
                  1:       return {4'hC, x, kk};
                  2:       return {4'hD, x, y, n};
                  3:       return {4'hE, x, 8'hA1};
                  4:       return {4'hF, x, 8'h07};
                  default: return {4'hF, x, 8'h33};
               endcase
         endcase
      end
   endfunction

   function automatic logic [15:0] rand_skip();
      logic [3:0] x;
      logic [3:0] y;
      begin
         x = 4'($urandom);
         y = 4'($urandom);
         case ($urandom % 4)
            0:       return {4'h3, x, 8'($urandom % 4)};   // small kk so it is taken now and then
            1:       return {4'h4, x, 8'($urandom % 4)};
            2:       return {4'h5, x, y, 4'h0};
            default: return {4'h9, x, y, 4'h0};
         endcase
      end
   endfunction

   // forward only and always to a unit start
   function automatic chip8_isa_pkg::addr_t jump_target(input int u);
      return unit_at[u + 1 + ($urandom % (N_UNITS - u))];
   endfunction

   task automatic gen_program();
      int                   ty [N_UNITS];
      int                   call_idx;
      chip8_isa_pkg::addr_t a;
      chip8_isa_pkg::addr_t ta;
      logic [7:0]           k;
      begin
         words.delete();
         call_idx = $urandom % N_UNITS;
         a        = chip8_isa_pkg::PROG_START;
         for (int u = 0; u < N_UNITS; u++)
         begin
            ty[u]      = (u == call_idx) ? 6 : int'($urandom % 6);
            unit_at[u] = a;
            a          = a + 12'(2 * unit_len(ty[u]));
         end
         unit_at[N_UNITS] = a;
         for (int u = 0; u < N_UNITS; u++)
            case (ty[u])
               0: words.push_back(rand_simple());
               1:
               begin
                  words.push_back(rand_skip());
                  words.push_back(rand_simple());
               end
               2: words.push_back({4'h1, jump_target(u)});
               3:
               begin
                  k  = 8'(2 * ($urandom % 4));
                  ta = jump_target(u);
                  words.push_back({8'h60, k});
                  words.push_back({4'hB, ta - {4'h0, k}});
               end
               4, 5:
               begin
                  words.push_back({4'hA, 12'hE00 + 12'($urandom % 'h81)});   // scratch
                  words.push_back({4'hF, 4'($urandom), 8'h1E});
                  words.push_back({4'hF, 4'($urandom), (ty[u] == 4) ? 8'h55 : 8'h65});
               end
               default: words.push_back({4'h2, a + 12'd2});
            endcase
         words.push_back({4'h1, a});
         words.push_back(rand_simple());   // subroutine
         words.push_back(rand_simple());
         words.push_back(16'h00EE);
      end
   endtask

   task automatic load_byte(input chip8_isa_pkg::addr_t addr, input chip8_isa_pkg::byte_t data);
      begin
         @(posedge clk);
         load_we_i   <= 1'b1;
         load_addr_i <= addr;
         load_data_i <= data;
      end
   endtask

   task automatic load_program();
      chip8_isa_pkg::addr_t a;
      begin
         a = chip8_isa_pkg::PROG_START;
         foreach (words[i])
         begin
            load_byte(a, words[i][15:8]);
            load_byte(a + 12'd1, words[i][7:0]);
            a = a + 12'd2;
         end
         @(posedge clk);
         load_we_i <= 1'b0;
      end
   endtask

   task automatic load_scratch();
      logic [11:0] a;
      begin
         for (int i = 'hE00; i <= 'hFFF; i++)
         begin
            a = 12'(i);
            load_byte(a, (a[7:0] * 8'd3) ^ {a[11:8], a[11:8]});
         end
         @(posedge clk);
         load_we_i <= 1'b0;
      end
   endtask

   task automatic pulse_reset();
      begin
         rst_n_i <= 1'b0;
         repeat (2) @(posedge clk);
         rst_n_i <= 1'b1;
      end
   endtask

   initial
   begin
      int pause_at;
      rst_n_i     = 1'b0;
      run_i       = 1'b0;
      load_we_i   = 1'b0;
      load_addr_i = '0;
      load_data_i = '0;
      void'($urandom(77432));
      repeat (2) @(posedge clk);
      rst_n_i <= 1'b1;
      load_scratch();
      for (int p = 0; p < NUM_PROGS; p++)
      begin
         if (p > 0)
            pulse_reset();
         gen_program();
         load_program();
         @(posedge clk);
         run_i    <= 1'b1;
         pause_at  = retire_cnt + 3 + int'($urandom % 8);
         if (p % 2 == 1)
         begin
            // an Fx55 must not start while the loader owns memory
            while (!prog_done && (retire_cnt < pause_at || store_next))
               @(posedge clk);
            run_i <= 1'b0;   // stop mid-program
            repeat (30) @(posedge clk);
            run_i <= 1'b1;
         end
         while (!prog_done)
            @(posedge clk);
         run_i <= 1'b0;
         repeat (30) @(posedge clk);
      end
      $display("errors: %0d, retired instructions: %0d", err_cnt, retire_cnt);
      if (err_cnt == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
src/chip8_isa_pkg.sv
src/chip8_core_pkg.sv
src/program_mem.sv
src/v_reg_file.sv
src/alu_8xy.sv
src/call_stack.sv
src/instr_sequencer.sv
src/chip8_top.sv
sim/chip8_checker.sv
sim/tb_chip8.sv
